//--- stream_pkg.sv
`default_nettype none

package stream_pkg;

  // one host link message
  typedef logic [31:0] xb_word_t;

  // routing tag, lowest two bits of every message
  typedef logic [1:0] msg_tag_t;

  // tag zero is pixel data unless a DRAM group is still open
  localparam msg_tag_t TAG_PIXEL = 2'b00;

  localparam int FP_SIZE = 20;
  // 2048 active rows plus dark rows above and below
  localparam int ROW_BITS = 12;
  localparam int COL_BITS = 11;
  localparam int FRAME_BITS = 20;

  // pixel message with the tag stripped
  // pixel in message bits 31:12, lval at bit 3, fval at bit 2
  typedef struct packed {
    logic [FP_SIZE-1:0] pixel;
    logic [7:0]         spare;
    logic               lval;
    logic               fval;
  } pixel_beat_t;

endpackage

`default_nettype wire

//--- dram_pkg.sv
`default_nettype none

package dram_pkg;

  // memory controller address width
  localparam int ADDR_WIDTH = 27;

  // first burst lands here
  localparam logic [ADDR_WIDTH-1:0] START_ADDR = '0;

  // BL8 burst, so the address moves by eight per burst
  localparam logic [ADDR_WIDTH-1:0] ADDR_INC = 27'd8;

  // data beats per write burst, low half first
  localparam int BEATS_PER_BURST = 2;

endpackage

`default_nettype wire

//--- sync_fifo.sv
`default_nettype none

module sync_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 16
) (
  input  logic     CLK,
  input  logic     fds_val,
  input  logic     push,
  input  payload_t din,
  input  logic     pop,
  output payload_t dout,
  output logic     empty,
  output logic     full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  // show-ahead: head word is always on dout
  assign dout  = mem[rd_ptr];
  assign empty = (count == 0);
  assign full  = (count == DEPTH);

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
    end
  end

  // the writer must look at full a cycle ahead of its push
  a_no_overflow: assert property (@(posedge CLK) disable iff (fds_val) push |-> !full)
    else $error("push into full FIFO");

  // reader side pops only a head that is present
  a_no_underflow: assert property (@(posedge CLK) disable iff (fds_val) pop |-> !empty)
    else $error("pop from empty FIFO");

endmodule

`default_nettype wire

//--- msg_router.sv
`default_nettype none

module msg_router import stream_pkg::*; #(
  parameter int APP_DATA_WIDTH = 128
) (
  input  logic        CLK,
  input  logic        fds_val,
  input  logic        pc_valid,
  input  xb_word_t    pc_data,
  output logic        pc_ready,
  input  logic        pix_full,
  input  logic        dram_full,
  output logic        pix_push,
  output pixel_beat_t pix_din,
  output logic        dram_push,
  output xb_word_t    dram_din
);

  // two memory beats worth of host words make one group
  localparam int GROUP_WORDS = 2 * APP_DATA_WIDTH / $bits(xb_word_t);
  localparam int CNT_W       = $clog2(GROUP_WORDS);

  logic [CNT_W-1:0] group_cnt;
  logic             xfer;
  logic             to_pixel;
  xb_word_t         word_q;

  // at most one word in flight, so the full flags seen here are never stale
  assign pc_ready = !pix_full && !dram_full && !pix_push && !dram_push;
  assign xfer     = pc_valid && pc_ready;
  assign to_pixel = (msg_tag_t'(pc_data[$bits(msg_tag_t)-1:0]) == TAG_PIXEL) && (group_cnt == 0);

  assign pix_din  = pixel_beat_t'(word_q[$bits(xb_word_t)-1:$bits(msg_tag_t)]);
  assign dram_din = word_q;

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      group_cnt <= '0;
      pix_push  <= 1'b0;
      dram_push <= 1'b0;
    end else begin
      pix_push  <= xfer && to_pixel;
      dram_push <= xfer && !to_pixel;
      if (xfer && !to_pixel) begin
        group_cnt <= (group_cnt == CNT_W'(GROUP_WORDS - 1)) ? '0 : group_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (xfer) begin
      word_q <= pc_data;
    end
  end

endmodule

`default_nettype wire

//--- frame_tracker.sv
`default_nettype none

module frame_tracker import stream_pkg::*; (
  input  logic                  CLK,
  input  logic                  fds_val,
  input  logic                  pix_empty,
  input  pixel_beat_t           pix_head,
  output logic                  pix_pop,
  output logic                  pix_valid,
  output logic [FP_SIZE-1:0]    pix_data,
  output logic [ROW_BITS-1:0]   pix_row,
  output logic [COL_BITS-1:0]   pix_col,
  output logic [FRAME_BITS-1:0] frame_num
);

  typedef enum logic [1:0] {
    ST_STANDBY,
    ST_INTRALINE,
    ST_INTERLINE,
    ST_INTERFRAME
  } state_t;

  state_t                state;
  logic [ROW_BITS-1:0]   row_cnt;
  // column of the next pixel on the line
  logic [COL_BITS-1:0]   col_cnt;
  logic [FRAME_BITS-1:0] frame_cnt;
  logic                  is_pixel;

  // camera data never stalls
  assign pix_pop  = !pix_empty;
  assign is_pixel = pix_pop && pix_head.lval && (state != ST_STANDBY);

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      state     <= ST_STANDBY;
      row_cnt   <= '0;
      col_cnt   <= '0;
      frame_cnt <= '0;
      pix_valid <= 1'b0;
    end else begin
      pix_valid <= is_pixel;
      if (pix_pop) begin
        case (state)
          ST_STANDBY: begin
            // sync up on a gap between frames
            if (!pix_head.fval) begin
              row_cnt   <= '0;
              col_cnt   <= '0;
              frame_cnt <= '0;
              state     <= ST_INTERFRAME;
            end
          end
          ST_INTRALINE: begin
            if (pix_head.lval) begin
              col_cnt <= col_cnt + 1'b1;
            end else if (pix_head.fval) begin
              row_cnt <= row_cnt + 1'b1;
              state   <= ST_INTERLINE;
            end else begin
              frame_cnt <= frame_cnt + 1'b1;
              state     <= ST_INTERFRAME;
            end
          end
          ST_INTERLINE: begin
            if (pix_head.lval) begin
              col_cnt <= COL_BITS'(1);
              state   <= ST_INTRALINE;
            end
          end
          default: begin
            if (pix_head.lval) begin
              row_cnt <= '0;
              col_cnt <= COL_BITS'(1);
              state   <= ST_INTRALINE;
            end
          end
        endcase
      end
    end
  end

  // first pixel of a line is column 0, first line of a frame is row 0
  always_ff @(posedge CLK) begin
    if (is_pixel) begin
      pix_data  <= pix_head.pixel;
      pix_row   <= (state == ST_INTERFRAME) ? '0 : row_cnt;
      pix_col   <= (state == ST_INTRALINE) ? col_cnt : '0;
      frame_num <= frame_cnt;
    end
  end

endmodule

`default_nettype wire

//--- burst_writer.sv
`default_nettype none

module burst_writer import stream_pkg::*, dram_pkg::*; #(
  parameter int APP_DATA_WIDTH = 128
) (
  input  logic                      CLK,
  input  logic                      fds_val,
  input  logic                      dram_empty,
  input  xb_word_t                  dram_head,
  output logic                      dram_pop,
  output logic                      app_en,
  output logic [ADDR_WIDTH-1:0]     app_addr,
  input  logic                      app_rdy,
  output logic                      app_wdf_wren,
  output logic                      app_wdf_end,
  output logic [APP_DATA_WIDTH-1:0] app_wdf_data,
  input  logic                      app_wdf_rdy,
  output logic                      error
);

  localparam int BURST_BITS = BEATS_PER_BURST * APP_DATA_WIDTH;
  localparam int WORD_BITS  = $bits(xb_word_t);
  localparam int WORDS      = BURST_BITS / WORD_BITS;
  localparam int CNT_W      = $clog2(WORDS);

  typedef enum logic [2:0] {
    BW_COLLECT,
    BW_ADDR,
    BW_BEAT1,
    BW_BEAT2,
    BW_ERROR
  } state_t;

  state_t                  state;
  logic [CNT_W-1:0]        word_cnt;
  logic [BURST_BITS-1:0]   burst_q;
  logic                    addr_ok;

  assign dram_pop = (state == BW_COLLECT) && !dram_empty;
  // command goes only when the data path can take the first beat too
  assign addr_ok  = app_rdy && app_wdf_rdy;
  assign error    = (state == BW_ERROR);

  always_ff @(posedge CLK or posedge fds_val) begin
    if (fds_val) begin
      state        <= BW_COLLECT;
      word_cnt     <= '0;
      app_en       <= 1'b0;
      app_addr     <= START_ADDR;
      app_wdf_wren <= 1'b0;
      app_wdf_end  <= 1'b0;
    end else begin
      case (state)
        BW_COLLECT: begin
          if (dram_pop) begin
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == CNT_W'(WORDS - 1)) begin
              app_en <= 1'b1;
              state  <= BW_ADDR;
            end
          end
        end
        BW_ADDR: begin
          if (addr_ok) begin
            app_en       <= 1'b0;
            app_addr     <= app_addr + ADDR_INC;
            app_wdf_wren <= 1'b1;
            state        <= BW_BEAT1;
          end
        end
        BW_BEAT1: begin
          if (app_wdf_rdy) begin
            app_wdf_end <= 1'b1;
            state       <= BW_BEAT2;
          end
        end
        BW_BEAT2: begin
          // the last beat gets one chance only
          app_wdf_wren <= 1'b0;
          app_wdf_end  <= 1'b0;
          state        <= app_wdf_rdy ? BW_COLLECT : BW_ERROR;
        end
        default: begin
        end
      endcase
    end
  end

  // first popped word ends up in the lowest bits
  always_ff @(posedge CLK) begin
    if (dram_pop) begin
      burst_q <= {dram_head, burst_q[BURST_BITS-1:WORD_BITS]};
    end
    if (state == BW_ADDR && addr_ok) begin
      app_wdf_data <= burst_q[APP_DATA_WIDTH-1:0];
    end else if (state == BW_BEAT1 && app_wdf_rdy) begin
      app_wdf_data <= burst_q[BURST_BITS-1 -: APP_DATA_WIDTH];
    end
  end

endmodule

`default_nettype wire

//--- cam_dram_top.sv
`default_nettype none

module cam_dram_top import stream_pkg::*, dram_pkg::*; #(
  parameter int APP_DATA_WIDTH = 128,
  parameter int FIFO_DEPTH     = 16
) (
  input  logic                      CLK,
  input  logic                      fds_val,
  input  logic                      pc_valid,
  input  xb_word_t                  pc_data,
  output logic                      pc_ready,
  output logic                      app_en,
  output logic [ADDR_WIDTH-1:0]     app_addr,
  input  logic                      app_rdy,
  output logic                      app_wdf_wren,
  output logic                      app_wdf_end,
  output logic [APP_DATA_WIDTH-1:0] app_wdf_data,
  input  logic                      app_wdf_rdy,
  output logic                      pix_valid,
  output logic [FP_SIZE-1:0]        pix_data,
  output logic [ROW_BITS-1:0]       pix_row,
  output logic [COL_BITS-1:0]       pix_col,
  output logic [FRAME_BITS-1:0]     frame_num,
  output logic                      error
);

  logic        pix_push, pix_pop, pix_empty, pix_full;
  pixel_beat_t pix_din, pix_head;
  logic        dram_push, dram_pop, dram_empty, dram_full;
  xb_word_t    dram_din, dram_head;

  msg_router #(.APP_DATA_WIDTH(APP_DATA_WIDTH)) u_router (
    .CLK(CLK), .fds_val(fds_val),
    .pc_valid(pc_valid), .pc_data(pc_data), .pc_ready(pc_ready),
    .pix_full(pix_full), .dram_full(dram_full),
    .pix_push(pix_push), .pix_din(pix_din),
    .dram_push(dram_push), .dram_din(dram_din)
  );

  sync_fifo #(.payload_t(pixel_beat_t), .DEPTH(FIFO_DEPTH)) u_pix_fifo (
    .CLK(CLK), .fds_val(fds_val),
    .push(pix_push), .din(pix_din),
    .pop(pix_pop), .dout(pix_head), .empty(pix_empty), .full(pix_full)
  );

  sync_fifo #(.payload_t(xb_word_t), .DEPTH(FIFO_DEPTH)) u_dram_fifo (
    .CLK(CLK), .fds_val(fds_val),
    .push(dram_push), .din(dram_din),
    .pop(dram_pop), .dout(dram_head), .empty(dram_empty), .full(dram_full)
  );

  frame_tracker u_tracker (
    .CLK(CLK), .fds_val(fds_val),
    .pix_empty(pix_empty), .pix_head(pix_head), .pix_pop(pix_pop),
    .pix_valid(pix_valid), .pix_data(pix_data),
    .pix_row(pix_row), .pix_col(pix_col), .frame_num(frame_num)
  );

  burst_writer #(.APP_DATA_WIDTH(APP_DATA_WIDTH)) u_writer (
    .CLK(CLK), .fds_val(fds_val),
    .dram_empty(dram_empty), .dram_head(dram_head), .dram_pop(dram_pop),
    .app_en(app_en), .app_addr(app_addr), .app_rdy(app_rdy),
    .app_wdf_wren(app_wdf_wren), .app_wdf_end(app_wdf_end),
    .app_wdf_data(app_wdf_data), .app_wdf_rdy(app_wdf_rdy),
    .error(error)
  );

endmodule

`default_nettype wire

//--- tb_cam_dram_top.sv
`default_nettype none

module tb_cam_dram_top
  import stream_pkg::*, dram_pkg::*;
();

  localparam int APP_DATA_WIDTH = 128;
  localparam int GROUP_WORDS    = 8;
  localparam int HOLD_CYCLES    = 120;
  localparam int CHK_W          = APP_DATA_WIDTH + 8;
  localparam int M_STANDBY      = 0;
  localparam int M_LINE         = 1;
  localparam int M_GAP          = 2;
  localparam int M_FRAME_GAP    = 3;

  logic                      CLK;
  logic                      fds_val;
  logic                      pc_valid;
  xb_word_t                  pc_data;
  logic                      pc_ready;
  logic                      app_en;
  logic [ADDR_WIDTH-1:0]     app_addr;
  logic                      app_rdy;
  logic                      app_wdf_wren;
  logic                      app_wdf_end;
  logic [APP_DATA_WIDTH-1:0] app_wdf_data;
  logic                      app_wdf_rdy;
  logic                      pix_valid;
  logic [FP_SIZE-1:0]        pix_data;
  logic [ROW_BITS-1:0]       pix_row;
  logic [COL_BITS-1:0]       pix_col;
  logic [FRAME_BITS-1:0]     frame_num;
  logic                      error;

  // rows of the cases file, eight words each
  logic [127:0] line_name [$];
  int           line_mode [$];
  xb_word_t     line_word [$];

  logic [127:0] cur_name;
  int           cur_mode;
  xb_word_t     words [$];
  int           widx;
  logic         host_xfer;
  logic [31:0]  rng;
  int           hold_cnt;
  int           low_run;
  int           max_low_run;
  logic         err_seen;
  int           value_errs;
  int           other_errs;
  int           cycle_limit = 1000000;

  // reference model
  logic [62:0]               exp_pix [$];
  logic [ADDR_WIDTH-1:0]     exp_addr [$];
  logic [APP_DATA_WIDTH:0]   exp_beat [$];
  xb_word_t                  burst_words [$];
  int                        burst_idx;
  int                        grp_cnt;
  int                        m_state;
  logic [ROW_BITS-1:0]       m_row;
  logic [COL_BITS-1:0]       m_col;
  logic [FRAME_BITS-1:0]     m_frame;

  cam_dram_top #(.APP_DATA_WIDTH(APP_DATA_WIDTH), .FIFO_DEPTH(16)) u_dut (.*);

  initial begin
    CLK = 1'b0;
    forever begin
      #4 CLK = ~CLK;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string what, input logic [CHK_W-1:0] exp,
                             input logic [CHK_W-1:0] act);
    if (exp !== act) begin
      value_errs++;
      $display("Fail %0s %0s: expected %0h, actual %0h", cur_name, what, exp, act);
    end
  endtask

  task automatic frame_model(input xb_word_t w);
    logic fv;
    logic lv;
    fv = w[2];
    lv = w[3];
    if (m_state == M_STANDBY) begin
      if (!fv) begin
        m_row   = '0;
        m_col   = '0;
        m_frame = '0;
        m_state = M_FRAME_GAP;
      end
    end else if (m_state == M_LINE) begin
      if (lv) begin
        exp_pix.push_back({w[31:12], m_row, m_col, m_frame});
        m_col = m_col + COL_BITS'(1);
      end else if (fv) begin
        m_row   = m_row + ROW_BITS'(1);
        m_state = M_GAP;
      end else begin
        m_frame = m_frame + FRAME_BITS'(1);
        m_state = M_FRAME_GAP;
      end
    end else if (lv) begin
      // first pixel of a line, row restarts only on a new frame
      if (m_state == M_FRAME_GAP) begin
        m_row = '0;
      end
      m_col = '0;
      exp_pix.push_back({w[31:12], m_row, m_col, m_frame});
      m_col   = COL_BITS'(1);
      m_state = M_LINE;
    end
  endtask

  task automatic dram_model(input xb_word_t w);
    logic [APP_DATA_WIDTH-1:0] lo;
    logic [APP_DATA_WIDTH-1:0] hi;
    burst_words.push_back(w);
    if (burst_words.size() == GROUP_WORDS) begin
      lo = {burst_words[3], burst_words[2], burst_words[1], burst_words[0]};
      hi = {burst_words[7], burst_words[6], burst_words[5], burst_words[4]};
      exp_addr.push_back(START_ADDR + ADDR_INC * ADDR_WIDTH'(burst_idx));
      exp_beat.push_back({1'b0, lo});
      // refused last beat never gets accepted
      if (cur_mode != 2) begin
        exp_beat.push_back({1'b1, hi});
      end
      burst_idx++;
      burst_words.delete();
    end
  endtask

  task automatic route_word(input xb_word_t w);
    if (w[1:0] == TAG_PIXEL && grp_cnt == 0) begin
      frame_model(w);
    end else begin
      dram_model(w);
      grp_cnt = (grp_cnt + 1) % GROUP_WORDS;
    end
  endtask

  task automatic apply_reset();
    @(negedge CLK);
    fds_val  = 1'b1;
    pc_valid = 1'b0;
    repeat (5) @(negedge CLK);
    fds_val = 1'b0;
    check_value("reset state", CHK_W'({4'b0000, START_ADDR}),
                CHK_W'({error, app_en, app_wdf_wren, pix_valid, app_addr}));
  endtask

  task automatic drive_cycle();
    @(negedge CLK);
    rng = xorshift(rng);
    if (host_xfer) begin
      widx++;
      pc_valid = 1'b0;
    end
    // a word stays on offer until taken
    if (!pc_valid && widx < words.size() && rng[4:3] != 2'b00) begin
      pc_valid = 1'b1;
      pc_data  = words[widx];
    end
    if (hold_cnt > 0) begin
      app_rdy = 1'b0;
      hold_cnt--;
    end else begin
      app_rdy = rng[0] | rng[1];
    end
    // memory model for the error test, last beat of a burst refused
    if (cur_mode == 2) begin
      if (app_en) begin
        app_wdf_rdy = 1'b1;
      end else if (app_wdf_wren && app_wdf_end) begin
        app_wdf_rdy = 1'b0;
      end else begin
        app_wdf_rdy = rng[2];
      end
    end
  endtask

  task automatic run_test();
    exp_pix.delete();
    exp_addr.delete();
    exp_beat.delete();
    burst_words.delete();
    burst_idx = 0;
    grp_cnt   = 0;
    m_state   = M_STANDBY;
    m_row     = '0;
    m_col     = '0;
    m_frame   = '0;
    widx      = 0;
    hold_cnt  = (cur_mode == 1) ? HOLD_CYCLES : 0;
    app_wdf_rdy = 1'b1;
    apply_reset();
    low_run     = 0;
    max_low_run = 0;
    err_seen    = 1'b0;
    foreach (words[k]) begin
      route_word(words[k]);
    end
    while (widx < words.size()) begin
      drive_cycle();
    end
    while (exp_pix.size() + exp_addr.size() + exp_beat.size() != 0 ||
           (cur_mode == 2 && !error)) begin
      drive_cycle();
    end
    // extra cycles catch late or duplicated outputs
    repeat (20) drive_cycle();
    if (cur_mode == 1 && max_low_run < 16) begin
      other_errs++;
      $display("pc_ready did not stay low under back-pressure in test %0s", cur_name);
    end
    if (cur_mode == 2) begin
      check_value("error held", CHK_W'(1), CHK_W'(error));
    end
  endtask

  always @(posedge CLK) begin
    host_xfer = pc_valid && pc_ready;
    if (!fds_val) begin
      low_run = pc_ready ? 0 : low_run + 1;
      if (low_run > max_low_run) begin
        max_low_run = low_run;
      end
      if (error && cur_mode != 2 && !err_seen) begin
        err_seen = 1'b1;
        other_errs++;
        $display("error flag raised during test %0s", cur_name);
      end
      if (pix_valid && exp_pix.size() == 0) begin
        other_errs++;
        $display("unexpected pixel output in test %0s", cur_name);
      end else if (pix_valid) begin
        check_value("pixel", CHK_W'(exp_pix.pop_front()),
                    CHK_W'({pix_data, pix_row, pix_col, frame_num}));
      end
      if (app_en && app_rdy && exp_addr.size() == 0) begin
        other_errs++;
        $display("unexpected write command in test %0s", cur_name);
      end else if (app_en && app_rdy) begin
        check_value("address", CHK_W'(exp_addr.pop_front()), CHK_W'(app_addr));
      end
      if (app_wdf_wren && app_wdf_rdy && exp_beat.size() == 0) begin
        other_errs++;
        $display("unexpected write beat in test %0s", cur_name);
      end else if (app_wdf_wren && app_wdf_rdy) begin
        check_value("beat", CHK_W'(exp_beat.pop_front()),
                    CHK_W'({app_wdf_end, app_wdf_data}));
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge CLK);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d value errors, %0d other errors",
             cycles, value_errs, other_errs);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin : main
    int               fd;
    int               r;
    int               md;
    int               i;
    logic [127:0]     nm;
    logic [8*256-1:0] text;
    xb_word_t         lw [8];
    fds_val     = 1'b1;
    pc_valid    = 1'b0;
    pc_data     = '0;
    app_rdy     = 1'b0;
    app_wdf_rdy = 1'b1;
    host_xfer   = 1'b0;
    rng         = 32'hc702;
    value_errs  = 0;
    other_errs  = 0;
    cur_name    = "setup";
    cur_mode    = 0;
    hold_cnt    = 0;
    fd = $fopen("cam_dram_cases.txt", "r");
    if (fd != 0) begin
      while ($fgets(text, fd) != 0) begin
        r = $sscanf(text, "%s %d %h %h %h %h %h %h %h %h", nm, md,
                    lw[0], lw[1], lw[2], lw[3], lw[4], lw[5], lw[6], lw[7]);
        // comment and blank lines never give a full row
        if (r == 10) begin
          line_name.push_back(nm);
          line_mode.push_back(md);
          for (int k = 0; k < 8; k++) begin
            line_word.push_back(lw[k]);
          end
        end
      end
      $fclose(fd);
    end
    if (line_name.size() == 0) begin
      other_errs++;
      $display("no test cases could be read from cam_dram_cases.txt");
    end
    cycle_limit = 20 * line_word.size() + 200;
    i = 0;
    while (i < line_name.size()) begin
      cur_name = line_name[i];
      cur_mode = line_mode[i];
      words.delete();
      while (i < line_name.size() && line_name[i] == cur_name) begin
        for (int k = 0; k < 8; k++) begin
          words.push_back(line_word[8 * i + k]);
        end
        i++;
      end
      run_test();
    end
    // error must clear on reset after the last test
    apply_reset();
    $display("%0d value errors, %0d other errors", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- cam_dram_cases.txt
# columns: test name, mode (0 plain, 1 long app_rdy stall, 2 refused last beat),
# then eight host message words in hex; rows with the same name form one test
pixel_framing 0 00000000 0010100C 0010200C 0010300C 0010400C 00000004 0020100C 0020200C
pixel_framing 0 0020300C 0020400C 00000004 0030100C 0030200C 0030300C 0030400C 00000000
pixel_framing 0 0040100C 0040200C 0040300C 0040400C 00000000 00000004 00000004 00000004
dram_grouping 0 A0000001 00000000 1230000C 4560000C 7890000C ABC00008 DEF0000C 00000004
dram_grouping 0 00000000 0050100C 0050200C 0050300C 00000000 00000004 00000004 00000000
dram_grouping 0 C0000003 0000000C 0000000C 0000000C 0000000C 0000000C 0000000C 00000000
burst_pack 0 01000001 02000000 03000000 04000000 05000000 06000000 07000000 08000000
burst_pack 0 09000002 0A000000 0B000000 0C000000 0D000000 0E000000 0F000000 10000003
back_pressure 1 1000A001 1000A010 1000A020 1000A030 1000A040 1000A050 1000A060 1000A070
back_pressure 1 00000000 0060100C 0060200C 00000004 0060300C 0060400C 00000000 00000004
back_pressure 1 2000B002 2000B111 2000B222 2000B333 2000B444 2000B555 2000B666 2000B777
back_pressure 1 3000C003 3000C008 3000C00C 3000C004 3000C000 3000C00C 3000C008 3000C004
back_pressure 1 4000D001 4000D002 4000D003 4000D000 4000D001 4000D002 4000D003 4000D000
error_flag 2 5000E001 5000E102 5000E203 5000E300 5000E401 5000E502 5000E603 5000E700

//--- cam_dram_top.f
stream_pkg.sv
dram_pkg.sv
sync_fifo.sv
msg_router.sv
frame_tracker.sv
burst_writer.sv
cam_dram_top.sv
tb_cam_dram_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_cam_dram_top
FILELIST  ?= cam_dram_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
